/* bench/eth_loop_sva.sv */
/*
	Transmit stage checks.
	Reset values, a stalled beat held steady, user only on the
	last byte, and no output while waiting for a record.
*/
`timescale 1ns/1ps

module eth_loop_sva (
	input logic clk,
	input logic rst_n,
	input logic ctl_ready,
	input logic out_valid,
	input logic out_ready,
	input eth_stream_pkg::byte_beat_t out_beat,
	input eth_loop_pkg::tx_state_t state
);

	reset_low: assert property (@(posedge clk) !rst_n |=> !ctl_ready && !out_valid)
		else $error("ctl_ready or out_valid high during reset");

	// a stalled beat stays put until taken.
	hold_beat: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else $error("out_beat changed or out_valid fell while stalled");

	user_on_last: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && out_beat.user |-> out_beat.last)
		else $error("out user set on a byte that is not the last");

	idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		state == eth_loop_pkg::wait_ctl |-> !out_valid)
		else $error("out_valid high while waiting for a control record");

endmodule

bind eth_frame_loop_tx eth_loop_sva u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.ctl_ready(ctl_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_beat(out_beat),
	.state(state)
);

/* bench/eth_loop_tb.sv */
/*
	Testbench for the Ethernet checksum loopback.
	Replays input frames from a data file with random gaps, holds
	out_ready low at random, and checks every output byte against
	the expected frames.
*/
`timescale 1ns/1ps

module eth_loop_tb;
	localparam int MAX_ENTRIES = 1024;
	localparam int DRAIN_CYCLES = 40; // idle window that catches extra bytes.

	logic clk;
	logic rst_n;
	eth_stream_pkg::byte_beat_t in_beat;
	logic in_valid;
	logic in_ready;
	eth_stream_pkg::byte_beat_t out_beat;
	logic out_valid;
	logic out_ready;

	logic [15:0] testdata [MAX_ENTRIES];
	eth_stream_pkg::byte_beat_t in_q[$];
	eth_stream_pkg::byte_beat_t exp_q[$];
	eth_stream_pkg::byte_beat_t exp_beat;
	int case_id_q[$]; // test number of each frame case.
	bit case_out_q[$]; // case has an output frame.
	int n_entries;
	int cycle_limit;
	int cycles = 0;
	int errors = 0;
	int frames_done = 0;
	int frames_expected = 0;
	int beats_checked = 0;
	int frame_beats = 0;
	int frame_errors = 0;
	bit running = 1'b0;

	eth_loop_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	always #10 clk = ~clk; // 20 ns period.

	// entry layout is tag[15:12], last[9], user[8], data[7:0].
	function automatic eth_stream_pkg::byte_beat_t entry_beat(input logic [15:0] e);
		eth_stream_pkg::byte_beat_t b;
		b.data = e[7:0];
		b.last = e[9];
		b.user = e[8];
		return b;
	endfunction

	task automatic load_testdata();
		bit had_out;
		bit done;
		had_out = 1'b0;
		done = 1'b0;
		n_entries = 0;
		$readmemh("bench/eth_loop_testdata.hex", testdata);
		for (int i = 0; i < MAX_ENTRIES && !done; i++) begin
			case (testdata[i][15:12])
				4'h1: in_q.push_back(entry_beat(testdata[i]));
				4'h2: begin
					exp_q.push_back(entry_beat(testdata[i]));
					had_out = 1'b1;
				end
				4'h3: begin // closes one frame case.
					case_id_q.push_back(int'(testdata[i][7:0]));
					case_out_q.push_back(had_out);
					if (had_out) begin
						frames_expected++;
					end
					had_out = 1'b0;
				end
				default: done = 1'b1;
			endcase
			n_entries++;
		end
	endtask

	task automatic compare_beat(input eth_stream_pkg::byte_beat_t got,
			input eth_stream_pkg::byte_beat_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: out_beat byte %0d got %02h/%0b/%0b expected %02h/%0b/%0b",
				$time, frame_beats, got.data, got.last, got.user,
				exp.data, exp.last, exp.user);
			errors++;
			frame_errors++;
		end
	endtask

	// cases that expect no output are done once the next frame is.
	task automatic report_drops();
		while (case_out_q.size() > 0 && !case_out_q[0]) begin
			void'(case_out_q.pop_front());
			$display("test %0d: dropped, no output", case_id_q.pop_front());
		end
	endtask

	task automatic report_frame();
		report_drops();
		if (case_id_q.size() > 0) begin
			void'(case_out_q.pop_front());
			$display("test %0d: frame of %0d bytes, %0d errors",
				case_id_q.pop_front(), frame_beats, frame_errors);
		end
		frames_done++;
		frame_beats = 0;
		frame_errors = 0;
	endtask

	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("ERROR at %0d ns: extra output byte %02h with no frame expected",
					$time, out_beat.data);
				errors++;
			end else begin
				exp_beat = exp_q.pop_front();
				compare_beat(out_beat, exp_beat);
				frame_beats++;
				beats_checked++;
				if (exp_beat.last) begin
					report_frame();
				end
			end
		end
	end

	always @(posedge clk) begin
		if (running) begin
			out_ready <= ($urandom_range(3, 0) != 0); // stalls about a quarter of cycles.
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("ERROR: timeout after %0d cycles, %0d expected bytes never came out",
				cycles, exp_q.size());
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_beat = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		void'($urandom(32'hbbbb5e4c));
		load_testdata();
		cycle_limit = 8 * n_entries + 1000;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		running <= 1'b1;
		foreach (in_q[i]) begin
			while ($urandom_range(3, 0) == 0) begin // random idle gap.
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_beat <= in_q[i];
			in_valid <= 1'b1;
			@(posedge clk);
			while (!in_ready) begin
				@(posedge clk);
			end
		end
		in_valid <= 1'b0;
		while (exp_q.size() > 0) begin
			@(posedge clk);
		end
		repeat (DRAIN_CYCLES) @(posedge clk);
		report_drops();
		$display("frames %0d of %0d, bytes checked %0d, errors %0d",
			frames_done, frames_expected, beats_checked, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* bench/eth_loop_testdata.hex */
// tag[15:12] 1 input beat, 2 expected output beat, 3 end of frame case (low byte = test)
// 0 end of data; bit 9 last, bit 8 user, bits 7:0 data byte
// test 1 udp, wrong ip and udp checksums
1002 1000 1000 1000 1000 1001 1002 1000 1000 1000 1000 1002 1008 1000 1045 1000
1000 101E 1012 1034 1000 1000 1040 1011 10DE 10AD 10C0 10A8 1001 1001 10C0 10A8
1001 1002 1004 1000 1000 1035 1000 100A 10BE 10EF 10AB 12CD
2002 2000 2000 2000 2000 2001 2002 2000 2000 2000 2000 2002 2008 2000 2045 2000
2000 201E 2012 2034 2000 2000 2040 2011 20E5 2047 20C0 20A8 2001 2001 20C0 20A8
2001 2002 2004 2000 2000 2035 2000 200A 20CC 2083 20AB 22CD 3001
// test 2 tcp syn, checksum at word 25
1002 1000 1000 1000 1000 1001 1002 1000 1000 1000 1000 1002 1008 1000 1045 1000
1000 1028 1000 1001 1040 1000 1040 1006 1000 1000 100A 1000 1000 1001 100A 1000
1000 1002 1030 1039 1000 1050 1000 1000 1000 1001 1000 1000 1000 1000 1050 1002
1072 1010 1000 1000 1000 1200
2002 2000 2000 2000 2000 2001 2002 2000 2000 2000 2000 2002 2008 2000 2045 2000
2000 2028 2000 2001 2040 2000 2040 2006 2026 20CD 200A 2000 2000 2001 200A 2000
2000 2002 2030 2039 2000 2050 2000 2000 2000 2001 2000 2000 2000 2000 2050 2002
2072 2010 20F9 2045 2000 2200 3002
// test 3 non-ipv4 passes through
1002 1000 1000 1000 1000 1001 1002 1000 1000 1000 1000 1002 1008 1006 1000 1001
1008 1000 1006 1004 1000 1001 1002 1000 1000 1000 1000 1202
2002 2000 2000 2000 2000 2001 2002 2000 2000 2000 2000 2002 2008 2006 2000 2001
2008 2000 2006 2004 2000 2001 2002 2000 2000 2000 2000 2202 3003
// test 4 ipv4 with ihl 6 passes through
1002 1000 1000 1000 1000 1001 1002 1000 1000 1000 1000 1002 1008 1000 1046 1000
1000 1018 1000 1009 1000 1000 1040 1011 1011 1022 10C0 10A8 1001 1001 10C0 10A8
1001 1002 1094 1004 1000 1200
2002 2000 2000 2000 2000 2001 2002 2000 2000 2000 2000 2002 2008 2000 2046 2000
2000 2018 2000 2009 2000 2000 2040 2011 2011 2022 20C0 20A8 2001 2001 20C0 20A8
2001 2002 2094 2004 2000 2200 3004
// test 5 runt of 10 bytes, no output
1002 1000 1000 1000 1000 1001 1002 1000 1000 1200 3005
// test 6 bad fcs on input
1002 1000 1000 1000 1000 1001 1002 1000 1000 1000 1000 1002 1088 10B5 1012 1334
2002 2000 2000 2000 2000 2001 2002 2000 2000 2000 2000 2002 2088 20B5 2012 2334 3006
// test 7 udp with 3-byte payload and 3 bytes of padding
1002 1000 1000 1000 1000 1001 1002 1000 1000 1000 1000 1002 1008 1000 1045 1000
1000 101F 1000 1007 1000 1000 1080 1011 1000 1000 10C0 10A8 1000 100A 10C0 10A8
1000 1014 1013 1088 1013 1089 1000 100B 1000 1000 1041 1042 1043 1055 1055 1255
2002 2000 2000 2000 2000 2001 2002 2000 2000 2000 2000 2002 2008 2000 2045 2000
2000 201F 2000 2007 2000 2000 2080 2011 20B9 2058 20C0 20A8 2000 200A 20C0 20A8
2000 2014 2013 2088 2013 2089 2000 200B 20D3 2015 2041 2042 2043 2055 2055 2255 3007
0000

/* filelist.f */
+incdir+src
src/eth_stream_pkg.sv
src/eth_loop_pkg.sv
src/eth_frame_fifo.sv
src/eth_csum_inspect.sv
src/eth_frame_loop_tx.sv
src/eth_loop_top.sv
bench/eth_loop_sva.sv
bench/eth_loop_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the checksum loopback testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module eth_loop_tb -o eth_loop_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/eth_loop_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

/* src/eth_csum_inspect.sv */
/*
	Frame inspector.
	Walks the Ethernet/IPv4 header of each frame, sums the IP
	header and the TCP/UDP datagram with its pseudo header, and
	hands one control record per frame to the transmit stage.
*/
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module eth_csum_inspect (
	input logic clk,
	input logic rst_n,

	input eth_stream_pkg::byte_beat_t in_beat,
	input logic in_fire,
	output logic in_ready,

	output eth_stream_pkg::frame_ctl_t ctl,
	output logic ctl_valid,
	input logic ctl_ready
);
	eth_loop_pkg::hdr_phase_t phase, phase_nxt;

	logic [`ETH_FIFO_AW-1:0] pos; // byte index within the frame.
	logic [15:0] pos_w;
	logic [7:0] hi_byte; // even byte, waiting for its pair.
	logic [7:0] proto;
	logic [15:0] total_len;
	logic [15:0] word;
	logic [15:0] hdr_sum, hdr_sum_nxt;
	logic [15:0] tr_sum, tr_sum_nxt;
	logic ip_ok, ip_ok_nxt;
	logic dgram_last; // final byte of the ip datagram.
	logic is_udp, is_tcp;
	logic [9:0] tr_word;
	logic [15:0] tr_fin;
	eth_stream_pkg::frame_ctl_t ctl_nxt;

	// 16-bit add with end-around carry.
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

	assign in_ready = ~ctl_valid; // one record in flight at a time.

	assign pos_w = {{(16 - `ETH_FIFO_AW){1'b0}}, pos};
	assign word = {hi_byte, in_beat.data};
	assign dgram_last = (pos_w + 16'd1 == 16'(`ETH_HDR_LEN) + total_len);
	assign is_udp = (proto == `ETH_PROTO_UDP);
	assign is_tcp = (proto == `ETH_PROTO_TCP);
	assign tr_word = is_tcp ? 10'(`ETH_TCP_CSUM_WORD) : 10'(`ETH_UDP_CSUM_WORD);

	always_comb begin
		phase_nxt = phase;
		hdr_sum_nxt = hdr_sum;
		tr_sum_nxt = tr_sum;
		ip_ok_nxt = ip_ok;
		case (phase)
			eth_loop_pkg::eth_hdr: begin
				if (pos == 11'd13) begin // ethertype complete.
					phase_nxt = (word == `ETH_TYPE_IPV4) ? eth_loop_pkg::ip_hdr : eth_loop_pkg::skip;
				end
			end
			eth_loop_pkg::ip_hdr: begin
				if (pos[0]) begin
					if (pos != 11'd25) begin // header checksum counts as zero.
						hdr_sum_nxt = ones_add(hdr_sum, word);
					end
					if (pos >= 11'd27) begin // source and destination address.
						tr_sum_nxt = ones_add(tr_sum, word);
					end
				end else if (pos == 11'd18) begin
					tr_sum_nxt = ones_add(tr_sum, total_len - 16'd20); // pseudo header length.
				end else if (pos == 11'd24) begin
					tr_sum_nxt = ones_add(tr_sum, {8'h00, proto});
				end
				if (pos == 11'd14 && in_beat.data != 8'h45) begin
					phase_nxt = eth_loop_pkg::skip; // not ipv4 or has options.
				end else if (pos == 11'd33) begin
					ip_ok_nxt = 1'b1;
					phase_nxt = dgram_last ? eth_loop_pkg::skip : eth_loop_pkg::payload;
				end
			end
			eth_loop_pkg::payload: begin
				if (pos[0]) begin
					if (pos[10:1] != tr_word) begin
						tr_sum_nxt = ones_add(tr_sum, word);
					end
				end else if (dgram_last) begin
					tr_sum_nxt = ones_add(tr_sum, {in_beat.data, 8'h00}); // odd tail.
				end
				if (dgram_last) begin
					phase_nxt = eth_loop_pkg::skip; // rest is ethernet padding.
				end
			end
			default: ;
		endcase
	end

	assign tr_fin = ~tr_sum_nxt;

	always_comb begin
		ctl_nxt.ip_csum = ip_ok_nxt ? ~hdr_sum_nxt : 16'd0;
		ctl_nxt.tr_csum = 16'd0;
		ctl_nxt.tr_pos = 15'd0;
		if (ip_ok_nxt && is_tcp) begin
			ctl_nxt.tr_csum = tr_fin;
			ctl_nxt.tr_pos = 15'(`ETH_TCP_CSUM_WORD);
		end else if (ip_ok_nxt && is_udp) begin
			ctl_nxt.tr_csum = (tr_fin == 16'd0) ? 16'hffff : tr_fin; // zero means no checksum.
			ctl_nxt.tr_pos = 15'(`ETH_UDP_CSUM_WORD);
		end
		ctl_nxt.drop = (pos_w + 16'd1 < 16'(`ETH_MIN_FRAME));
		ctl_nxt.fcs_bad = in_beat.user;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= eth_loop_pkg::eth_hdr;
			pos <= '0;
			hdr_sum <= 16'd0;
			tr_sum <= 16'd0;
			ip_ok <= 1'b0;
			ctl_valid <= 1'b0;
		end else begin
			if (ctl_valid && ctl_ready) begin
				ctl_valid <= 1'b0;
			end
			if (in_fire) begin
				if (in_beat.last) begin // start over for the next frame.
					phase <= eth_loop_pkg::eth_hdr;
					pos <= '0;
					hdr_sum <= 16'd0;
					tr_sum <= 16'd0;
					ip_ok <= 1'b0;
					ctl_valid <= 1'b1;
				end else begin
					phase <= phase_nxt;
					pos <= pos + 1'b1;
					hdr_sum <= hdr_sum_nxt;
					tr_sum <= tr_sum_nxt;
					ip_ok <= ip_ok_nxt;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			if (!pos[0]) begin
				hi_byte <= in_beat.data;
			end
			if (pos == 11'd17) begin
				total_len <= word;
			end
			if (pos == 11'd23) begin
				proto <= in_beat.data;
			end
			if (in_beat.last) begin
				ctl <= ctl_nxt;
			end
		end
	end

endmodule

/* src/eth_frame_fifo.sv */
/*
	Byte-wide frame buffer.
	Circular store with a valid/ready port on each side;
	the head entry is shown on the output.
*/
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module eth_frame_fifo (
	input logic clk,
	input logic rst_n,

	input eth_stream_pkg::byte_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,

	output eth_stream_pkg::byte_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);
	eth_stream_pkg::byte_beat_t mem [`ETH_FIFO_DEPTH];

	logic [`ETH_FIFO_AW-1:0] wr_ptr, rd_ptr;
	logic [`ETH_FIFO_AW:0] count; // occupancy, one bit wider than the pointers.
	logic wr_en, rd_en;

	assign in_ready = (count != `ETH_FIFO_DEPTH);
	assign out_valid = (count != '0);
	assign out_beat = mem[rd_ptr];

	assign wr_en = in_valid & in_ready;
	assign rd_en = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_beat;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at the depth.
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/eth_frame_loop_tx.sv */
/*
	Frame replay stage.
	Takes one control record per frame, then streams the stored
	bytes out with the checksum fields overwritten, or drains the
	frame when it is to be dropped.
*/
`timescale 1ns/1ps
`include "eth_loop_defs.svh"

module eth_frame_loop_tx (
	input logic clk,
	input logic rst_n,

	input eth_stream_pkg::frame_ctl_t ctl,
	input logic ctl_valid,
	output logic ctl_ready,

	input eth_stream_pkg::byte_beat_t frame_beat,
	input logic frame_valid,
	output logic frame_ready,

	output eth_stream_pkg::byte_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);
	eth_loop_pkg::tx_state_t state;
	eth_stream_pkg::frame_ctl_t cur; // record of the frame being sent.

	logic [15:0] count; // bytes sent so far.
	logic [15:0] patch;
	logic use_patch;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= eth_loop_pkg::wait_ctl;
			count <= 16'd0;
			ctl_ready <= 1'b0;
		end else begin
			case (state)
				eth_loop_pkg::wait_ctl: begin
					ctl_ready <= 1'b1;
					if (ctl_ready && ctl_valid) begin
						state <= ctl.drop ? eth_loop_pkg::drop_frame : eth_loop_pkg::tx_frame;
						count <= 16'd0;
						ctl_ready <= 1'b0;
					end
				end
				eth_loop_pkg::tx_frame: begin
					if (out_valid && out_ready) begin
						count <= count + 16'd1;
						if (out_beat.last) begin
							state <= eth_loop_pkg::wait_ctl;
						end
					end
				end
				eth_loop_pkg::drop_frame: begin
					if (frame_valid && frame_beat.last) begin // one byte per cycle.
						state <= eth_loop_pkg::wait_ctl;
					end
				end
				default: state <= eth_loop_pkg::wait_ctl;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == eth_loop_pkg::wait_ctl && ctl_ready && ctl_valid) begin
			cur <= ctl;
		end
	end

	// pick the checksum that lands on the current 16-bit word.
	always_comb begin
		use_patch = 1'b0;
		patch = 16'd0;
		if (cur.ip_csum != 16'd0 && count[15:1] == 15'(`ETH_IP_CSUM_WORD)) begin
			use_patch = 1'b1;
			patch = cur.ip_csum;
		end else if (cur.tr_csum != 16'd0 && count[15:1] == cur.tr_pos) begin
			use_patch = 1'b1;
			patch = cur.tr_csum;
		end
	end

	always_comb begin
		out_beat = '0;
		out_valid = 1'b0;
		frame_ready = 1'b0;
		case (state)
			eth_loop_pkg::tx_frame: begin
				if (use_patch) begin
					out_beat.data = count[0] ? patch[7:0] : patch[15:8]; // high byte first.
				end else begin
					out_beat.data = frame_beat.data;
				end
				out_beat.last = frame_beat.last;
				out_beat.user = cur.fcs_bad & frame_beat.last;
				out_valid = frame_valid;
				frame_ready = out_ready;
			end
			eth_loop_pkg::drop_frame: frame_ready = 1'b1;
			default: ;
		endcase
	end

endmodule

/* src/eth_loop_defs.svh */
/*
	Ethernet checksum loopback constants.
	Buffer sizing, frame offsets and protocol numbers.
*/
`ifndef ETH_LOOP_DEFS_SVH
`define ETH_LOOP_DEFS_SVH

`define ETH_FIFO_DEPTH 2048 // bytes, holds one full frame.
`define ETH_FIFO_AW 11

`define ETH_HDR_LEN 14 // ip header starts here.
`define ETH_IP_CSUM_WORD 12
`define ETH_UDP_CSUM_WORD 20
`define ETH_TCP_CSUM_WORD 25

`define ETH_TYPE_IPV4 16'h0800
`define ETH_PROTO_TCP 8'd6
`define ETH_PROTO_UDP 8'd17

`define ETH_MIN_FRAME 14 // shorter frames are runts.

`endif

/* src/eth_loop_pkg.sv */
/*
	State encodings for the checksum loopback.
*/
package eth_loop_pkg;

	// transmit stage FSM.
	typedef enum logic [1:0] {
		wait_ctl,
		tx_frame,
		drop_frame
	} tx_state_t;

	// where the inspector is within a frame.
	typedef enum logic [1:0] {
		eth_hdr,
		ip_hdr,
		payload,
		skip
	} hdr_phase_t;

endpackage

/* src/eth_loop_top.sv */
/*
	Ethernet checksum loopback.
	The input stream feeds the frame buffer and the inspector
	together; the transmit stage replays each buffered frame
	under the inspector's control record.
*/
`timescale 1ns/1ps

module eth_loop_top (
	input logic clk,
	input logic rst_n,

	input eth_stream_pkg::byte_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,

	output eth_stream_pkg::byte_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);
	eth_stream_pkg::byte_beat_t fifo_beat;
	eth_stream_pkg::frame_ctl_t ctl;

	logic fifo_in_ready, inspect_ready;
	logic fifo_valid, fifo_ready;
	logic ctl_valid, ctl_ready;
	logic in_fire;

	assign in_ready = fifo_in_ready & inspect_ready; // both sides take every byte.
	assign in_fire = in_valid & in_ready;

	eth_frame_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.in_beat(in_beat),
		.in_valid(in_fire),
		.in_ready(fifo_in_ready),
		.out_beat(fifo_beat),
		.out_valid(fifo_valid),
		.out_ready(fifo_ready)
	);

	eth_csum_inspect u_inspect (
		.clk(clk),
		.rst_n(rst_n),
		.in_beat(in_beat),
		.in_fire(in_fire),
		.in_ready(inspect_ready),
		.ctl(ctl),
		.ctl_valid(ctl_valid),
		.ctl_ready(ctl_ready)
	);

	eth_frame_loop_tx u_tx (
		.clk(clk),
		.rst_n(rst_n),
		.ctl(ctl),
		.ctl_valid(ctl_valid),
		.ctl_ready(ctl_ready),
		.frame_beat(fifo_beat),
		.frame_valid(fifo_valid),
		.frame_ready(fifo_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

/* src/eth_stream_pkg.sv */
/*
	Stream types for the checksum loopback.
	A byte beat on the data path and the per-frame
	control record from the inspector to the transmit stage.
*/
package eth_stream_pkg;

	// one byte on a stream.
	typedef struct packed {
		logic [7:0] data;
		logic last;
		logic user; // fcs error on input, marked fcs on output.
	} byte_beat_t;

	// per-frame instructions for the replay.
	// a zero checksum leaves that field as received.
	typedef struct packed {
		logic [15:0] ip_csum;
		logic [15:0] tr_csum;
		logic [14:0] tr_pos; // 16-bit word index of the transport checksum.
		logic drop;
		logic fcs_bad;
	} frame_ctl_t;

endpackage
